//--- logic/cart_loader_defs.svh
`ifndef CART_LOADER_DEFS_SVH
`define CART_LOADER_DEFS_SVH

// Host download index decode
`define CL_INDEX_ROM_MAX    6'h01       // Low six index bits up to this load ROM
`define CL_INDEX_CODE       8'hFF       // Cheat code download
`define CL_INDEX_CART_BIT   6           // Set for a cartridge image, clear for BIOS

// Cartridge header
`define CL_HDR_REGION_ADDR  25'h1F0     // First region character

// Word-addressed external memory windows
`define CL_CART_PREFIX      2'b00       // Cart ROM
`define CL_BIOS_PREFIX      6'b011110   // BIOS ROM

// Sizes
`define CL_BANK_COUNT       8
`define CL_CODE_WORDS       8

// Any mask bit here set means a ROM above 4 MB
`define CL_LARGE_ROM_BITS   23:22

`endif

//--- logic/cart_loader_pkg.sv
package cart_loader_pkg;

	// Host download port
	typedef logic [24:0] ioctl_addr_t;   // Byte address
	typedef logic [15:0] ioctl_data_t;   // One 16-bit word per strobe
	typedef logic  [7:0] load_index_t;

	// External memory word address
	typedef logic [23:0] mem_addr_t;

	// CPU word address without bit 0
	typedef logic [23:1] cpu_addr_t;
	typedef logic  [4:0] bank_t;         // Selects one 512 KB bank

	// Size mask kept over the upper address bits only
	typedef logic [23:13] rom_mask_t;

	// 0 JP, 1 US, 2 EU
	typedef logic  [1:0] region_t;

	// Cheat code fields
	//   127:96  flags
	//    95:64  address
	//    63:32  compare value
	//    31:0   replace value
	typedef logic [127:0] cheat_code_t;

endpackage

//--- logic/load_if.sv
`timescale 1ns/1ns

interface load_if import cart_loader_pkg::*; ();

	logic        wr;         // One cycle per host word
	ioctl_addr_t addr;
	ioctl_data_t data;
	logic        is_rom;     // ROM download active
	logic        is_code;    // Cheat download active
	logic        cart_mode;  // Image targets the cartridge window

	modport source (
		output wr, addr, data, is_rom, is_code, cart_mode
	);

	modport sink (
		input wr, addr, data, is_rom, is_code, cart_mode
	);

endinterface

//--- logic/download_decoder.sv
`timescale 1ns/1ns
`include "cart_loader_defs.svh"

module download_decoder import cart_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        ioctl_download,
	input  load_index_t ioctl_index,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_data,
	output logic        ioctl_wait,

	input  logic        mem_busy,
	output logic        mem_wr,
	output mem_addr_t   mem_addr,
	output ioctl_data_t mem_din,

	load_if.source      ld
);

	logic rom_dl;
	logic code_dl;
	logic cart_sel;
	logic rom_write;
	logic wr_pending;  // Memory write outstanding
	logic busy_d;

	////////////////////////////////////////
	// Download kind

	assign rom_dl    = ioctl_download & (ioctl_index[5:0] <= `CL_INDEX_ROM_MAX);
	assign code_dl   = ioctl_download & (ioctl_index == `CL_INDEX_CODE);
	assign cart_sel  = ioctl_index[`CL_INDEX_CART_BIT];
	assign rom_write = rom_dl & ioctl_wr;

	assign ld.wr        = ioctl_wr;
	assign ld.addr      = ioctl_addr;
	assign ld.data      = ioctl_data;
	assign ld.is_rom    = rom_dl;
	assign ld.is_code   = code_dl;
	assign ld.cart_mode = cart_sel;

	////////////////////////////////////////
	// Memory write path

	always_ff @(posedge clk_sys) begin
		if (rom_write) begin
			if (cart_sel)
				mem_addr <= {`CL_CART_PREFIX, ioctl_addr[22:1]};
			else
				mem_addr <= {`CL_BIOS_PREFIX, ioctl_addr[18:1]};
			mem_din <= {ioctl_data[7:0], ioctl_data[15:8]};  // Memory is byte swapped
		end
	end

	// Stall the host until the memory drops busy
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_pending <= 1'b0;
			busy_d     <= 1'b0;
		end else begin
			busy_d <= mem_busy;
			if (rom_write)
				wr_pending <= 1'b1;
			else if (busy_d & ~mem_busy)
				wr_pending <= 1'b0;  // Write done
		end
	end

	assign ioctl_wait = wr_pending;
	assign mem_wr     = wr_pending;

	a_no_wr_while_wait: assert property (
		@(posedge clk_sys) disable iff (reset) ioctl_wr |-> !ioctl_wait
	) else $error("host write while ioctl_wait is high");

endmodule

//--- logic/rom_header_scan.sv
`timescale 1ns/1ns
`include "cart_loader_defs.svh"

module rom_header_scan import cart_loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	load_if.sink      ld,
	output region_t   region,
	output rom_mask_t rom_mask,
	output logic      cart_mode
);

	logic    rom_write;
	logic    hdr_hit;
	region_t hdr_region;

	assign rom_write = ld.wr & ld.is_rom;
	assign hdr_hit   = (ld.addr == `CL_HDR_REGION_ADDR);

	// First region character of the header
	always_comb begin
		case (ld.data[7:0])
			"J":     hdr_region = 2'd0;
			"U":     hdr_region = 2'd1;
			default: hdr_region = 2'd2;  // Anything else is EU
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask  <= '0;
			cart_mode <= 1'b0;
			region    <= 2'd0;
		end else if (rom_write) begin
			cart_mode <= ld.cart_mode;

			// Mask grows with the highest address seen
			if (ld.cart_mode) begin
				if (ld.addr == '0)
					rom_mask <= '0;  // New image
				else
					rom_mask <= rom_mask | ld.addr[23:13];
			end

			if (hdr_hit)
				region <= hdr_region;
		end
	end

endmodule

//--- logic/cheat_code_loader.sv
`timescale 1ns/1ns
`include "cart_loader_defs.svh"

module cheat_code_loader import cart_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	load_if.sink        ld,
	output cheat_code_t code,
	output logic        code_valid,
	output logic        code_reset
);

	// Byte offset of the closing word
	localparam logic [3:0] LAST_OFFSET = 4'(2 * (`CL_CODE_WORDS - 1));

	logic code_write;

	assign code_write = ld.wr & ld.is_code;

	// Bottom word of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			case (ld.addr[3:0])
				4'd0:  code[111:96]  <= ld.data;  // Flags
				4'd2:  code[127:112] <= ld.data;
				4'd4:  code[79:64]   <= ld.data;  // Address
				4'd6:  code[95:80]   <= ld.data;
				4'd8:  code[47:32]   <= ld.data;  // Compare
				4'd10: code[63:48]   <= ld.data;
				4'd12: code[15:0]    <= ld.data;  // Replace
				4'd14: code[31:16]   <= ld.data;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Strobes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= code_write & (ld.addr[3:0] == LAST_OFFSET);
			code_reset <= code_write & (ld.addr == '0);  // Start of a new code list
		end
	end

	a_valid_one_cycle: assert property (
		@(posedge clk_sys) disable iff (reset) code_valid |=> !code_valid
	) else $error("code_valid held for more than one cycle");

endmodule

//--- logic/bank_mapper.sv
`timescale 1ns/1ns
`include "cart_loader_defs.svh"

module bank_mapper import cart_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        rom_loading,
	input  logic        page_ce_n,
	input  logic        cpu_rnw,
	input  cpu_addr_t   cpu_va,
	input  ioctl_data_t cpu_dout,
	input  rom_mask_t   rom_mask,
	output cpu_addr_t   rom_va
);

	bank_t bank_regs [`CL_BANK_COUNT];

	logic ce_q;   // Sampled page select
	logic ce_d;
	logic page_fall;
	logic large_rom;
	logic bank_write;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_q <= 1'b1;
			ce_d <= 1'b1;
		end else begin
			ce_q <= page_ce_n;
			ce_d <= ce_q;
		end
	end

	assign page_fall  = ce_d & ~ce_q;
	assign large_rom  = |rom_mask[`CL_LARGE_ROM_BITS];
	assign bank_write = page_fall & large_rom & ~cpu_rnw & (cpu_va[3:1] != 3'd0);

	////////////////////////////////////////
	// Bank registers

	always_ff @(posedge clk_sys) begin
		if (reset | rom_loading) begin
			for (int i = 0; i < `CL_BANK_COUNT; i++)
				bank_regs[i] <= bank_t'(i);  // Identity map
		end else if (bank_write) begin
			bank_regs[cpu_va[3:1]] <= cpu_dout[4:0];
		end
	end

	// Bank replaces the top three CPU address bits
	assign rom_va = {bank_regs[cpu_va[21:19]], cpu_va[18:1]} & {rom_mask, 12'hFFF};

	// First bank always maps the vectors
	a_bank0_fixed: assert property (
		@(posedge clk_sys) disable iff (reset) bank_regs[0] == '0
	) else $error("bank register 0 changed");

endmodule

//--- logic/cart_loader_top.sv
`timescale 1ns/1ns

module cart_loader_top import cart_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,

	// Host download
	input  logic        ioctl_download,
	input  load_index_t ioctl_index,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_data,
	output logic        ioctl_wait,

	// External memory
	input  logic        mem_busy,
	output logic        mem_wr,
	output mem_addr_t   mem_addr,
	output ioctl_data_t mem_din,

	// CPU page access
	input  logic        page_ce_n,
	input  logic        cpu_rnw,
	input  cpu_addr_t   cpu_va,
	input  ioctl_data_t cpu_dout,
	output cpu_addr_t   rom_va,

	// Cartridge info
	output region_t     region,
	output logic        cart_mode,

	// Cheats
	output cheat_code_t code,
	output logic        code_valid,
	output logic        code_reset
);

	load_if ld ();

	rom_mask_t rom_mask;
	logic      rom_loading;

	assign rom_loading = ld.is_rom;  // Mapper stays at identity while loading

	////////////////////////////////////////
	// Download side

	download_decoder u_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.mem_busy       (mem_busy),
		.mem_wr         (mem_wr),
		.mem_addr       (mem_addr),
		.mem_din        (mem_din),
		.ld             (ld.source)
	);

	rom_header_scan u_header_scan (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ld        (ld.sink),
		.region    (region),
		.rom_mask  (rom_mask),
		.cart_mode (cart_mode)
	);

	cheat_code_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ld         (ld.sink),
		.code       (code),
		.code_valid (code_valid),
		.code_reset (code_reset)
	);

	////////////////////////////////////////
	// CPU side

	bank_mapper u_bank_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rom_loading (rom_loading),
		.page_ce_n   (page_ce_n),
		.cpu_rnw     (cpu_rnw),
		.cpu_va      (cpu_va),
		.cpu_dout    (cpu_dout),
		.rom_mask    (rom_mask),
		.rom_va      (rom_va)
	);

endmodule

//--- test/tb_cart_loader.sv
`timescale 1ns/1ns

module tb_cart_loader import cart_loader_pkg::*; ();

	localparam int ROM_WORDS  = 40;  // Per load mode
	localparam int CODES      = 4;
	localparam int PAGE_OPS   = 24;  // Per mapper test
	localparam int MAP_CHECKS = 8;
	localparam int N_TXN = 2 * ROM_WORDS + 3 + CODES * 8
		+ 2 * (2 + 2 * PAGE_OPS + MAP_CHECKS) + MAP_CHECKS + 20;
	localparam int TIMEOUT_NS = N_TXN * 20 * 8;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_download;
	load_index_t ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_data;
	logic        ioctl_wait;
	logic        mem_busy;
	logic        mem_wr;
	mem_addr_t   mem_addr;
	ioctl_data_t mem_din;
	logic        page_ce_n;
	logic        cpu_rnw;
	cpu_addr_t   cpu_va;
	ioctl_data_t cpu_dout;
	cpu_addr_t   rom_va;
	region_t     region;
	logic        cart_mode;
	cheat_code_t code;
	logic        code_valid;
	logic        code_reset;

	logic [31:0] seed;
	logic [31:0] mem_seed;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_errors;
	string       test_name;

	logic [15:0] mem_model [int];  // What the DUT wrote
	logic [15:0] ref_mem [int];    // What it should have written
	bank_t       ref_bank [8];
	rom_mask_t   ref_mask;
	logic        mem_wr_q;
	int          busy_left;

	cart_loader_top u_dut (.*);

	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] rand32();
		seed = xorshift(seed);
		return seed;
	endfunction

	////////////////////////////////////////
	// External memory model busy for 1 to 6 cycles per write

	always @(posedge clk_sys) begin
		mem_wr_q <= mem_wr;
		if (reset) begin
			mem_busy  <= 1'b0;
			busy_left <= 0;
		end else if (mem_wr && !mem_wr_q) begin
			mem_model[int'(mem_addr)] = mem_din;
			mem_seed = xorshift(mem_seed);
			busy_left <= int'(mem_seed % 6) + 1;
			mem_busy  <= 1'b1;
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else if (busy_left == 1) begin
			busy_left <= 0;
			mem_busy  <= 1'b0;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog: run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors) begin
			$display("[test] %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("[test] %s: failed with %0d errors", test_name, errors - test_errors);
		end
	endtask

	task automatic report_mismatch(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		$display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		errors++;
	endtask

	////////////////////////////////////////
	// Host side

	task automatic begin_download(input load_index_t index);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		if (index[5:0] <= 6'd1) begin
			for (int i = 0; i < 8; i++)
				ref_bank[i] = bank_t'(i);  // ROM load resets the mapper
		end
		@(posedge clk_sys);
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic rom_write(input ioctl_addr_t addr, input ioctl_data_t data);
		int        waited;
		mem_addr_t exp_addr;
		waited = 0;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_data <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		if (ioctl_wait !== 1'b1 || mem_wr !== 1'b1) begin
			$display("ERROR %s: no wait or memory write raised for address %h",
				test_name, addr);
			errors++;
		end
		while (ioctl_wait === 1'b1 && waited < 40) begin
			@(negedge clk_sys);
			waited++;
		end
		if (ioctl_wait !== 1'b0) begin
			$display("ERROR %s: ioctl_wait never released after address %h",
				test_name, addr);
			errors++;
		end else if (mem_busy === 1'b1) begin
			$display("ERROR %s: ioctl_wait released while memory busy at address %h",
				test_name, addr);
			errors++;
		end
		if (ioctl_index[6]) begin
			exp_addr = {2'b00, addr[22:1]};
			if (addr == '0)
				ref_mask = '0;
			else
				ref_mask |= addr[23:13];
		end else begin
			exp_addr = {6'b011110, addr[18:1]};
		end
		ref_mem[int'(exp_addr)] = {data[7:0], data[15:8]};
	endtask

	task automatic code_write(input ioctl_addr_t addr, input ioctl_data_t data,
		output logic valid, output logic rst);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_data <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		valid = code_valid;
		rst   = code_reset;
	endtask

	////////////////////////////////////////
	// CPU side

	task automatic page_access(input logic [2:0] idx, input ioctl_data_t dout, input logic rnw);
		logic [31:0] r;
		r = rand32();
		@(posedge clk_sys);
		page_ce_n <= 1'b0;
		cpu_rnw   <= rnw;
		cpu_va    <= {r[19:0], idx};
		cpu_dout  <= dout;
		repeat (3) @(posedge clk_sys);
		page_ce_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		cpu_rnw <= 1'b1;
		if (ref_mask[23:22] != 2'b00 && !rnw && idx != 3'd0)
			ref_bank[idx] = dout[4:0];
	endtask

	task automatic check_map(input int n);
		cpu_addr_t va;
		cpu_addr_t exp;
		for (int i = 0; i < n; i++) begin
			va = cpu_addr_t'(rand32());
			@(posedge clk_sys);
			cpu_va <= va;
			@(negedge clk_sys);
			exp = {ref_bank[va[21:19]], va[18:1]} & {ref_mask, 12'hFFF};
			if (rom_va !== exp)
				report_mismatch($sformatf("rom_va at %06h", va), exp, rom_va);
		end
	endtask

	////////////////////////////////////////
	// Tests

	task automatic reset_test();
		start_test("reset");
		@(negedge clk_sys);
		if (ioctl_wait !== 1'b0) report_mismatch("ioctl_wait", 0, ioctl_wait);
		if (mem_wr !== 1'b0) report_mismatch("mem_wr", 0, mem_wr);
		if (code_valid !== 1'b0) report_mismatch("code_valid", 0, code_valid);
		if (code_reset !== 1'b0) report_mismatch("code_reset", 0, code_reset);
		check_map(MAP_CHECKS);  // Zero mask
		end_test();
	endtask

	task automatic rom_load_test(input string name, input load_index_t index);
		logic [31:0] r;
		start_test(name);
		ref_mem.delete();
		mem_model.delete();
		begin_download(index);
		for (int i = 0; i < ROM_WORDS; i++) begin
			r = rand32();
			rom_write({1'b0, r[23:1], 1'b0}, ioctl_data_t'(rand32()));
		end
		end_download();
		if (cart_mode !== index[6])
			report_mismatch("cart_mode", index[6], cart_mode);
		foreach (ref_mem[k]) begin
			if (!mem_model.exists(k)) begin
				$display("ERROR %s: memory word %06h was never written", test_name, k);
				errors++;
			end else if (mem_model[k] !== ref_mem[k]) begin
				report_mismatch($sformatf("mem[%06h]", k), ref_mem[k], mem_model[k]);
			end
		end
		end_test();
	endtask

	task automatic header_test();
		logic [7:0] other;
		start_test("header_region");
		other = rand32();
		if (other == "J" || other == "U")
			other = "E";
		begin_download(8'h40);
		rom_write(25'h1F0, {8'h00, "J"});
		if (region !== 2'd0) report_mismatch("region J", 0, region);
		rom_write(25'h1F0, {8'h00, "U"});
		if (region !== 2'd1) report_mismatch("region U", 1, region);
		rom_write(25'h1F0, {8'h00, other});
		if (region !== 2'd2) report_mismatch("region other", 2, region);
		end_download();
		end_test();
	endtask

	task automatic cheat_test();
		ioctl_data_t words [8];
		int          order [8];
		int          j;
		int          tmp;
		int          n_valid;
		int          n_reset;
		logic        v;
		logic        rs;
		cheat_code_t exp;
		start_test("cheat_codes");
		begin_download(8'hFF);
		for (int c = 0; c < CODES; c++) begin
			n_valid = 0;
			n_reset = 0;
			for (int i = 0; i < 8; i++) begin
				words[i] = ioctl_data_t'(rand32());
				order[i] = i;
			end
			for (int i = 6; i > 0; i--) begin  // Closing word stays last
				j        = int'(rand32() % (i + 1));
				tmp      = order[i];
				order[i] = order[j];
				order[j] = tmp;
			end
			for (int i = 0; i < 8; i++) begin
				code_write(ioctl_addr_t'(16 * c + 2 * order[i]), words[order[i]], v, rs);
				n_valid += v;
				n_reset += rs;
			end
			@(negedge clk_sys);
			n_valid += code_valid;  // Pulse must be gone by now
			exp = {words[1], words[0], words[3], words[2],
				words[5], words[4], words[7], words[6]};
			if (n_valid != 1) report_mismatch("code_valid pulses", 1, n_valid);
			if (code !== exp) report_mismatch($sformatf("code %0d", c), exp, code);
			if (n_reset != (c == 0)) report_mismatch("code_reset pulses", c == 0, n_reset);
		end
		end_download();
		end_test();
	endtask

	task automatic mapper_test(input string name, input ioctl_addr_t top_addr);
		logic [31:0] r;
		start_test(name);
		begin_download(8'h40);
		rom_write('0, ioctl_data_t'(rand32()));
		rom_write(top_addr, ioctl_data_t'(rand32()));
		end_download();
		check_map(MAP_CHECKS);
		for (int i = 0; i < PAGE_OPS; i++) begin
			r = rand32();
			page_access(r[2:0], ioctl_data_t'(r[31:16]), r[4:3] == 2'b00);
			check_map(1);
		end
		end_test();
	endtask

	initial begin
		seed           = 32'h2bd4_70cf;
		mem_seed       = xorshift(32'h2bd4_70cf ^ 32'h5a5a_a5a5);
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		mem_busy       = 1'b0;
		page_ce_n      = 1'b1;
		cpu_rnw        = 1'b1;
		cpu_va         = '0;
		cpu_dout       = '0;
		ref_mask       = '0;
		for (int i = 0; i < 8; i++)
			ref_bank[i] = bank_t'(i);
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;

		reset_test();
		rom_load_test("rom_cart", 8'h40);
		rom_load_test("rom_bios", 8'h00);
		header_test();
		cheat_test();
		mapper_test("large_rom", 25'h07F_FFFE);         // Above 4 MB
		mapper_test("small_rom_reload", 25'h01F_FFFE);  // Reload also drops the banks

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- cart_loader.f
+incdir+logic
logic/cart_loader_pkg.sv
logic/load_if.sv
logic/download_decoder.sv
logic/rom_header_scan.sv
logic/cheat_code_loader.sv
logic/bank_mapper.sv
logic/cart_loader_top.sv
test/tb_cart_loader.sv

//--- Bender.yml
package:
  name: cart_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/cart_loader_pkg.sv
      - logic/load_if.sv
      - logic/download_decoder.sv
      - logic/rom_header_scan.sv
      - logic/cheat_code_loader.sv
      - logic/bank_mapper.sv
      - logic/cart_loader_top.sv
  - target: test
    files:
      - test/tb_cart_loader.sv
